/* rtl/ifetch_defines.svh */
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// data and address width
`define XLEN 32

// cache geometry, all as log2
`define CACHE_WORDS_LOG2 7
`define LINE_WORDS_LOG2 4
`define LINE_COUNT_LOG2 (`CACHE_WORDS_LOG2 - `LINE_WORDS_LOG2)

// high address bits outside the cached space
`define UNUSED_ADDR_BITS 10
`define TAG_BITS (`XLEN - `UNUSED_ADDR_BITS - `LINE_WORDS_LOG2 - 2)

// byte address of the vector table
`define VTABLE_BASE 32'h0000_0400

`endif

/* rtl/ifetch_pkg.sv */
`include "ifetch_defines.svh"

package ifetch_pkg;

  // fetch address split into its cache fields
  typedef struct packed {
    logic [`UNUSED_ADDR_BITS-1:0] unused;
    logic [`TAG_BITS-1:0]         tag;
    logic [`LINE_WORDS_LOG2-1:0]  word;
    logic [1:0]                   byte_off;
  } fetch_fields_t;

  typedef union packed {
    logic [`XLEN-1:0] raw;
    fetch_fields_t    f;
  } fetch_addr_u;

  typedef struct packed {
    logic                 valid;
    logic [`TAG_BITS-1:0] tag;
  } tag_entry_t;

  // wishbone classic master side, word addressed
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic [3:0]       sel;
    logic [`XLEN-3:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] dat;
    logic             ack;
    logic             err;
  } wb_rsp_t;

  // one bus user toward the arbiter
  typedef struct packed {
    logic             req;
    logic             stb;
    logic [`XLEN-3:0] adr;
  } bus_user_req_t;

endpackage

/* rtl/icache_data_ram.sv */
`timescale 1ns/100ps
`include "ifetch_defines.svh"

module icache_data_ram (
  input  logic                         clk_i,
  input  logic                         we_i,
  input  logic [`CACHE_WORDS_LOG2-1:0] waddr_i,
  input  logic [`XLEN-1:0]             wdata_i,
  input  logic                         re_i,
  input  logic [`CACHE_WORDS_LOG2-1:0] raddr_i,
  output logic [`XLEN-1:0]             rdata_o,
  output logic                         rvalid_o
);

  localparam int WORDS = 1 << `CACHE_WORDS_LOG2;

  logic [`XLEN-1:0] mem [WORDS];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read data holds until the next enabled read
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
    rvalid_o <= re_i;
  end

endmodule

/* rtl/icache_tag_store.sv */
`timescale 1ns/100ps
`include "ifetch_defines.svh"

module icache_tag_store (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  ifetch_pkg::fetch_addr_u     lookup_addr_i,
  output logic                        hit_o,
  output logic [`LINE_COUNT_LOG2-1:0] hit_line_o,
  output logic [`LINE_COUNT_LOG2-1:0] victim_line_o,
  input  logic                        install_i,
  input  ifetch_pkg::tag_entry_t      install_tag_i
);

  import ifetch_pkg::*;

  localparam int LINES = 1 << `LINE_COUNT_LOG2;

  tag_entry_t                  tags [LINES];
  logic [`LINE_COUNT_LOG2-1:0] rr_ptr;
  logic [LINES-1:0]            match_vec;
  logic [LINES-1:0]            dup_vec;

  // fully associative search over every line
  always_comb begin
    hit_o      = 1'b0;
    hit_line_o = '0;
    for (int i = 0; i < LINES; i++) begin
      match_vec[i] = tags[i].valid && (tags[i].tag == lookup_addr_i.f.tag);
      dup_vec[i]   = tags[i].valid && (tags[i].tag == install_tag_i.tag);
      if (match_vec[i]) begin
        hit_o      = 1'b1;
        hit_line_o = i[`LINE_COUNT_LOG2-1:0];
      end
    end
  end

  // oldest filled line is the next victim
  assign victim_line_o = rr_ptr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr <= '0;
      for (int j = 0; j < LINES; j++) begin
        tags[j].valid <= 1'b0;
      end
    end else if (install_i) begin
      tags[rr_ptr] <= install_tag_i;
      rr_ptr       <= rr_ptr + 1'b1;
    end
  end

  // a refill only follows a real miss, so a tag is never stored twice
  a_unique_tag : assert property (
    @(posedge clk_i) disable iff (reset_i)
    install_i |-> (dup_vec == '0)
  );

endmodule

/* rtl/icache_line_fill.sv */
`timescale 1ns/100ps
`include "ifetch_defines.svh"

module icache_line_fill (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         start_i,
  input  ifetch_pkg::fetch_addr_u      miss_addr_i,
  input  logic [`LINE_COUNT_LOG2-1:0]  victim_line_i,
  output logic                         busy_o,
  output ifetch_pkg::bus_user_req_t    bus_o,
  input  logic                         grant_i,
  input  ifetch_pkg::wb_rsp_t          rsp_i,
  output logic                         ram_we_o,
  output logic [`CACHE_WORDS_LOG2-1:0] ram_waddr_o,
  output logic                         install_o,
  output ifetch_pkg::tag_entry_t       install_tag_o
);

  import ifetch_pkg::*;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_ARB  = 2'd1;
  localparam logic [1:0] S_READ = 2'd2;
  localparam logic [1:0] S_DONE = 2'd3;

  logic [1:0]                  state;
  logic [`LINE_WORDS_LOG2-1:0] word_idx;
  fetch_addr_u                 miss_addr_q;
  logic [`LINE_COUNT_LOG2-1:0] line_q;
  logic                        word_ack;

  // ack only counts while this unit owns the bus
  assign word_ack = (state == S_READ) && grant_i && rsp_i.ack;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state    <= S_IDLE;
      word_idx <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start_i) begin
            state    <= S_ARB;
            word_idx <= '0;
          end
        end
        S_ARB: begin
          if (grant_i) begin
            state <= S_READ;
          end
        end
        S_READ: begin
          if (word_ack) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == '1) begin
              state <= S_DONE;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == S_IDLE) && start_i) begin
      miss_addr_q <= miss_addr_i;
      line_q      <= victim_line_i;
    end
  end

  assign busy_o = (state != S_IDLE);

  // next word address follows the counter, so reads run back to back
  assign bus_o.req = (state == S_ARB) || (state == S_READ);
  assign bus_o.stb = (state == S_READ);
  assign bus_o.adr = {{`UNUSED_ADDR_BITS{1'b0}}, miss_addr_q.f.tag, word_idx};

  assign ram_we_o    = word_ack;
  assign ram_waddr_o = {line_q, word_idx};

  assign install_o     = (state == S_DONE);
  assign install_tag_o = '{valid: 1'b1, tag: miss_addr_q.f.tag};

  // a granted ack with no refill running would be a stray slave reply
  a_no_idle_ack : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state == S_IDLE) |-> !(grant_i && rsp_i.ack)
  );

endmodule

/* rtl/vector_fetch.sv */
`timescale 1ns/100ps
`include "ifetch_defines.svh"

module vector_fetch (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      fetch_i,
  input  logic                      irq_i,
  input  logic [`XLEN-1:0]          vtable_offset_i,
  output logic                      pending_o,
  output logic                      busy_o,
  output ifetch_pkg::bus_user_req_t bus_o,
  input  logic                      grant_i,
  input  ifetch_pkg::wb_rsp_t       rsp_i,
  output logic [`XLEN-1:0]          vec_pc_o,
  output logic                      vec_pc_valid_o
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_ARB  = 2'd1;
  localparam logic [1:0] S_READ = 2'd2;
  localparam logic [1:0] S_DONE = 2'd3;

  localparam logic [`XLEN-1:0] VTABLE_BASE_C = `VTABLE_BASE;

  logic [1:0]       state;
  logic             not_vectored;
  logic             irq_catch;
  logic [`XLEN-3:0] vec_adr;
  logic             start;
  logic             vec_ack;

  assign pending_o = not_vectored | irq_catch;
  assign start     = (state == S_IDLE) && fetch_i && pending_o;
  assign vec_ack   = (state == S_READ) && grant_i && rsp_i.ack;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state          <= S_IDLE;
      not_vectored   <= 1'b1;
      irq_catch      <= 1'b0;
      vec_pc_valid_o <= 1'b0;
    end else begin
      vec_pc_valid_o <= vec_ack;
      // an interrupt during a lookup stays pending for the next one
      if (irq_i) begin
        irq_catch <= 1'b1;
      end else if (start) begin
        irq_catch <= 1'b0;
      end
      if (start) begin
        not_vectored <= 1'b0;
      end
      case (state)
        S_IDLE: if (start) state <= S_ARB;
        S_ARB:  if (grant_i) state <= S_READ;
        S_READ: if (vec_ack) state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // offset is taken when the bus is granted
  always_ff @(posedge clk_i) begin
    if ((state == S_ARB) && grant_i) begin
      vec_adr <= VTABLE_BASE_C[`XLEN-1:2] + vtable_offset_i[`XLEN-1:2];
    end
    if (vec_ack) begin
      vec_pc_o <= rsp_i.dat;
    end
  end

  assign busy_o    = (state != S_IDLE);
  assign bus_o.req = (state == S_ARB) || (state == S_READ);
  assign bus_o.stb = (state == S_READ);
  assign bus_o.adr = vec_adr;

  a_vec_pulse : assert property (
    @(posedge clk_i) disable iff (reset_i)
    vec_pc_valid_o |=> !vec_pc_valid_o
  );

endmodule

/* rtl/fetch_bus_arbiter.sv */
`timescale 1ns/100ps

module fetch_bus_arbiter (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  ifetch_pkg::bus_user_req_t vec_i,
  input  ifetch_pkg::bus_user_req_t fill_i,
  output logic                      vec_grant_o,
  output logic                      fill_grant_o,
  output logic                      bus_req_o,
  input  logic                      bus_grant_i,
  output ifetch_pkg::wb_req_t       wb_req_o
);

  import ifetch_pkg::*;

  localparam logic [1:0] OWN_NONE = 2'd0;
  localparam logic [1:0] OWN_VEC  = 2'd1;
  localparam logic [1:0] OWN_FILL = 2'd2;

  logic [1:0]    owner;
  bus_user_req_t sel_req;

  // vector fetch wins, owner holds until it drops req
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner <= OWN_NONE;
    end else begin
      case (owner)
        OWN_VEC:  if (!vec_i.req) owner <= OWN_NONE;
        OWN_FILL: if (!fill_i.req) owner <= OWN_NONE;
        default: begin
          if (vec_i.req) begin
            owner <= OWN_VEC;
          end else if (fill_i.req) begin
            owner <= OWN_FILL;
          end
        end
      endcase
    end
  end

  always_comb begin
    case (owner)
      OWN_VEC:  sel_req = vec_i;
      OWN_FILL: sel_req = fill_i;
      default:  sel_req = '0;
    endcase
  end

  assign bus_req_o    = vec_i.req | fill_i.req;
  assign vec_grant_o  = bus_grant_i && (owner == OWN_VEC);
  assign fill_grant_o = bus_grant_i && (owner == OWN_FILL);

  // no strobe leaves without the outside grant
  assign wb_req_o.stb = sel_req.stb && bus_grant_i;
  assign wb_req_o.cyc = sel_req.stb && bus_grant_i;
  assign wb_req_o.sel = 4'hF;
  assign wb_req_o.adr = sel_req.adr;

  // a requester strobes only while it holds its request
  a_stb_in_req : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (!vec_i.stb || vec_i.req) && (!fill_i.stb || fill_i.req)
  );

endmodule

/* rtl/ifetch_top.sv */
`timescale 1ns/100ps
`include "ifetch_defines.svh"

module ifetch_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                fetch_i,
  input  logic [`XLEN-1:0]    addr_i,
  input  logic                irq_i,
  input  logic [`XLEN-1:0]    vtable_offset_i,
  output logic                busy_o,
  output logic [`XLEN-1:0]    instr_o,
  output logic                instr_valid_o,
  output logic [`XLEN-1:0]    vec_pc_o,
  output logic                vec_pc_valid_o,
  output logic                bus_req_o,
  input  logic                bus_grant_i,
  output ifetch_pkg::wb_req_t wb_req_o,
  input  ifetch_pkg::wb_rsp_t wb_rsp_i
);

  import ifetch_pkg::*;

  fetch_addr_u                  lookup_addr;
  logic                         hit;
  logic [`LINE_COUNT_LOG2-1:0]  hit_line;
  logic [`LINE_COUNT_LOG2-1:0]  victim_line;
  logic                         install;
  tag_entry_t                   install_tag;
  logic                         vec_pending;
  logic                         vec_busy;
  logic                         fill_busy;
  logic                         fill_start;
  logic                         ram_re;
  logic                         ram_we;
  logic [`CACHE_WORDS_LOG2-1:0] ram_waddr;
  bus_user_req_t                vec_bus;
  bus_user_req_t                fill_bus;
  logic                         vec_grant;
  logic                         fill_grant;

  assign lookup_addr.raw = addr_i;

  // a pending vector takes the fetch instead of the cache
  assign ram_re     = fetch_i && hit && !vec_pending;
  assign fill_start = fetch_i && !hit && !vec_pending;
  assign busy_o     = vec_busy | fill_busy;

  icache_tag_store u_tags (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit),
    .hit_line_o    (hit_line),
    .victim_line_o (victim_line),
    .install_i     (install),
    .install_tag_i (install_tag)
  );

  icache_data_ram u_ram (
    .clk_i    (clk_i),
    .we_i     (ram_we),
    .waddr_i  (ram_waddr),
    .wdata_i  (wb_rsp_i.dat),
    .re_i     (ram_re),
    .raddr_i  ({hit_line, lookup_addr.f.word}),
    .rdata_o  (instr_o),
    .rvalid_o (instr_valid_o)
  );

  icache_line_fill u_fill (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (fill_start),
    .miss_addr_i   (lookup_addr),
    .victim_line_i (victim_line),
    .busy_o        (fill_busy),
    .bus_o         (fill_bus),
    .grant_i       (fill_grant),
    .rsp_i         (wb_rsp_i),
    .ram_we_o      (ram_we),
    .ram_waddr_o   (ram_waddr),
    .install_o     (install),
    .install_tag_o (install_tag)
  );

  vector_fetch u_vec (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_i         (fetch_i),
    .irq_i           (irq_i),
    .vtable_offset_i (vtable_offset_i),
    .pending_o       (vec_pending),
    .busy_o          (vec_busy),
    .bus_o           (vec_bus),
    .grant_i         (vec_grant),
    .rsp_i           (wb_rsp_i),
    .vec_pc_o        (vec_pc_o),
    .vec_pc_valid_o  (vec_pc_valid_o)
  );

  fetch_bus_arbiter u_arb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .vec_i        (vec_bus),
    .fill_i       (fill_bus),
    .vec_grant_o  (vec_grant),
    .fill_grant_o (fill_grant),
    .bus_req_o    (bus_req_o),
    .bus_grant_i  (bus_grant_i),
    .wb_req_o     (wb_req_o)
  );

  // instruction fetches are word aligned
  a_fetch_aligned : assert property (
    @(posedge clk_i) disable iff (reset_i)
    fetch_i |-> (lookup_addr.f.byte_off == 2'b00)
  );

endmodule

/* tb/wb_mem_model.sv */
`timescale 1ns/100ps
`include "ifetch_defines.svh"

module wb_mem_model #(
  parameter logic [`XLEN-3:0] VTABLE_WORD = '0,
  parameter logic [`XLEN-3:0] IRQ_WORD    = '0,
  parameter logic [`XLEN-1:0] RESET_PC    = '0,
  parameter logic [`XLEN-1:0] IRQ_PC      = '0
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [3:0]          ack_delay_i,
  input  ifetch_pkg::wb_req_t wb_req_i,
  output ifetch_pkg::wb_rsp_t wb_rsp_o,
  output logic [31:0]         read_count_o
);

  logic [3:0]       wait_cnt;
  logic             ack_q;
  logic [`XLEN-1:0] dat_q;

  // word n holds n times the golden ratio constant, two vector slots aside
  function automatic logic [`XLEN-1:0] word_at(input logic [`XLEN-3:0] adr);
    if (adr == VTABLE_WORD) begin
      return RESET_PC;
    end
    if (adr == IRQ_WORD) begin
      return IRQ_PC;
    end
    return {2'b00, adr} * 32'h9E37_79B9;
  endfunction

  assign wb_rsp_o = '{dat: dat_q, ack: ack_q, err: 1'b0};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q        <= 1'b0;
      dat_q        <= '0;
      wait_cnt     <= '0;
      read_count_o <= '0;
    end else begin
      ack_q <= 1'b0;
      // the ack cycle closes a transfer, the next address starts a fresh wait
      if (wb_req_i.cyc && wb_req_i.stb && !ack_q) begin
        if (wait_cnt >= ack_delay_i) begin
          ack_q        <= 1'b1;
          dat_q        <= word_at(wb_req_i.adr);
          wait_cnt     <= '0;
          read_count_o <= read_count_o + 1;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end else if (!wb_req_i.stb) begin
        wait_cnt <= '0;
      end
    end
  end

endmodule

/* tb/tb_ifetch.sv */
`timescale 1ns/100ps
`include "ifetch_defines.svh"

module tb_ifetch;

  import ifetch_pkg::*;

  localparam logic [31:0] RESET_PC    = 32'h0000_2000;
  localparam logic [31:0] IRQ_PC      = 32'h0000_5A40;
  localparam logic [31:0] IRQ_OFFSET  = 32'd12;
  localparam logic [29:0] VTABLE_WORD = 30'(`VTABLE_BASE >> 2);
  localparam logic [29:0] IRQ_WORD    = 30'((`VTABLE_BASE + IRQ_OFFSET) >> 2);
  localparam logic [31:0] HIT_BASE    = 32'h0000_1000;
  localparam logic [31:0] RR_BASE     = 32'h0000_2000;
  localparam logic [31:0] BP_BASE     = 32'h0000_3000;
  localparam logic [31:0] RAND_BASE   = 32'h0000_3400;
  // about 13 line fills and 5 hit runs, a few thousand cycles at most
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk_i;
  logic        reset_i;
  logic        fetch_i;
  logic [31:0] addr_i;
  logic        irq_i;
  logic [31:0] vtable_offset_i;
  logic        busy_o;
  logic [31:0] instr_o;
  logic        instr_valid_o;
  logic [31:0] vec_pc_o;
  logic        vec_pc_valid_o;
  logic        bus_req_o;
  logic        bus_grant_i;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [3:0]  ack_delay;
  logic [31:0] read_count;
  logic        grant_en;
  logic        rand_delay_en;
  logic [31:0] lfsr_state = 32'd91093;
  logic [3:0]  rand_bits;
  logic [29:0] ack_log [$];
  int          cycle_count = 0;

  ifetch_top u_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_i         (fetch_i),
    .addr_i          (addr_i),
    .irq_i           (irq_i),
    .vtable_offset_i (vtable_offset_i),
    .busy_o          (busy_o),
    .instr_o         (instr_o),
    .instr_valid_o   (instr_valid_o),
    .vec_pc_o        (vec_pc_o),
    .vec_pc_valid_o  (vec_pc_valid_o),
    .bus_req_o       (bus_req_o),
    .bus_grant_i     (bus_grant_i),
    .wb_req_o        (wb_req),
    .wb_rsp_i        (wb_rsp)
  );

  wb_mem_model #(
    .VTABLE_WORD (VTABLE_WORD),
    .IRQ_WORD    (IRQ_WORD),
    .RESET_PC    (RESET_PC),
    .IRQ_PC      (IRQ_PC)
  ) u_mem (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ack_delay_i  (ack_delay),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .read_count_o (read_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // expected memory contents, vector slots first
  function automatic logic [31:0] expected_word(input logic [29:0] adr);
    if (adr == VTABLE_WORD) begin
      return RESET_PC;
    end
    if (adr == IRQ_WORD) begin
      return IRQ_PC;
    end
    return {2'b00, adr} * 32'h9E37_79B9;
  endfunction

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_random_bits(input int count, output logic [3:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[2:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // outside bus owner grants one cycle after the request
  always @(posedge clk_i) begin
    bus_grant_i <= grant_en && bus_req_o;
  end

  // new ack delay of 0 to 3 cycles every clock in random mode
  always @(posedge clk_i) begin
    if (rand_delay_en) begin
      take_random_bits(2, rand_bits);
      ack_delay <= rand_bits;
    end
  end

  always @(posedge clk_i) begin
    if (wb_req.stb && wb_rsp.ack) begin
      ack_log.push_back(wb_req.adr);
    end
  end

  // cyc follows stb and every byte lane is read
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (wb_req.stb) begin
        check_value("wb cyc", wb_req.cyc, 1'b1);
        check_value("wb sel", wb_req.sel, 4'hF);
      end else begin
        check_value("wb cyc", wb_req.cyc, 1'b0);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic pulse_fetch(input logic [31:0] addr);
    @(posedge clk_i);
    fetch_i <= 1'b1;
    addr_i  <= addr;
    @(posedge clk_i);
    fetch_i <= 1'b0;
  endtask

  // fetch that must turn into a bus job, busy one cycle later
  task automatic start_busy_fetch(input logic [31:0] addr);
    pulse_fetch(addr);
    @(posedge clk_i);
    check_value("busy_o", busy_o, 1'b1);
    check_value("instr_valid_o", instr_valid_o, 1'b0);
  endtask

  task automatic run_until_idle(output int pulses, output logic [31:0] pc);
    pulses = 0;
    pc     = '0;
    while (busy_o) begin
      @(posedge clk_i);
      if (vec_pc_valid_o) begin
        pulses++;
        pc = vec_pc_o;
      end
    end
  endtask

  task automatic finish_fill(input logic [31:0] base, input int reads_before);
    int          pulses;
    logic [31:0] pc;
    run_until_idle(pulses, pc);
    check_value("vec_pc_valid_o pulses", pulses, 0);
    check_value("read count", read_count - reads_before, 16);
    check_value("ack log size", ack_log.size(), 16);
    for (int i = 0; i < 16; i++) begin
      check_value("wb adr", ack_log[i], base[31:2] + i);
    end
  endtask

  task automatic fill_line(input logic [31:0] base);
    int reads_before;
    reads_before = read_count;
    ack_log.delete();
    // miss in the middle of the line, refill still starts at word 0
    start_busy_fetch(base + 32'h14);
    finish_fill(base, reads_before);
  endtask

  task automatic check_line_hits(input logic [31:0] base);
    int reads_before;
    reads_before = read_count;
    for (int w = 0; w < 16; w++) begin
      pulse_fetch(base + 4 * w);
      @(posedge clk_i);
      check_value("busy_o", busy_o, 1'b0);
      check_value("instr_valid_o", instr_valid_o, 1'b1);
      check_value("instr_o", instr_o, expected_word(base[31:2] + w));
    end
    check_value("read count", read_count - reads_before, 0);
    check_value("bus_req_o", bus_req_o, 1'b0);
  endtask

  task automatic reset_vector_check();
    int          pulses;
    int          reads_before;
    logic [31:0] pc;
    reads_before = read_count;
    start_busy_fetch(32'h0);
    run_until_idle(pulses, pc);
    check_value("vec_pc_valid_o pulses", pulses, 1);
    check_value("vec_pc_o", pc, expected_word(VTABLE_WORD));
    check_value("read count", read_count - reads_before, 1);
  endtask

  task automatic miss_then_hit();
    fill_line(HIT_BASE);
    check_line_hits(HIT_BASE);
  endtask

  // eight lines in all, so the ninth fill lands on the first
  task automatic round_robin_eviction();
    for (int k = 0; k < 9; k++) begin
      fill_line(RR_BASE + 32'h40 * k);
    end
    fill_line(RR_BASE);
    check_line_hits(RR_BASE + 32'h40 * 8);
  endtask

  task automatic interrupt_vector();
    int          pulses;
    int          reads_before;
    logic [31:0] pc;
    @(posedge clk_i);
    vtable_offset_i <= IRQ_OFFSET;
    irq_i           <= 1'b1;
    @(posedge clk_i);
    irq_i <= 1'b0;
    reads_before = read_count;
    start_busy_fetch(RR_BASE + 32'h40 * 8);
    run_until_idle(pulses, pc);
    check_value("vec_pc_valid_o pulses", pulses, 1);
    check_value("vec_pc_o", pc, expected_word(IRQ_WORD));
    check_value("read count", read_count - reads_before, 1);
    vtable_offset_i <= 32'd0;
    check_line_hits(RR_BASE + 32'h40 * 8);
  endtask

  task automatic grant_backpressure();
    int reads_before;
    @(posedge clk_i);
    grant_en <= 1'b0;
    reads_before = read_count;
    ack_log.delete();
    start_busy_fetch(BP_BASE);
    repeat (50) begin
      @(posedge clk_i);
      check_value("busy_o", busy_o, 1'b1);
      check_value("wb stb", wb_req.stb, 1'b0);
      check_value("bus_req_o", bus_req_o, 1'b1);
    end
    grant_en <= 1'b1;
    finish_fill(BP_BASE, reads_before);
    check_line_hits(BP_BASE);
  endtask

  task automatic random_ack_delays();
    @(posedge clk_i);
    rand_delay_en <= 1'b1;
    fill_line(RAND_BASE);
    rand_delay_en <= 1'b0;
    check_line_hits(RAND_BASE);
  endtask

  initial begin
    reset_i         = 1'b1;
    fetch_i         = 1'b0;
    addr_i          = '0;
    irq_i           = 1'b0;
    vtable_offset_i = '0;
    bus_grant_i     = 1'b0;
    ack_delay       = 4'd1;
    grant_en        = 1'b1;
    rand_delay_en   = 1'b0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    reset_vector_check();
    miss_then_hit();
    round_robin_eviction();
    interrupt_vector();
    grant_backpressure();
    random_ack_delays();

    @(posedge clk_i);
    $display("Test OK");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/ifetch_pkg.sv
rtl/icache_data_ram.sv
rtl/icache_tag_store.sv
rtl/icache_line_fill.sv
rtl/vector_fetch.sv
rtl/fetch_bus_arbiter.sv
rtl/ifetch_top.sv
tb/wb_mem_model.sv
tb/tb_ifetch.sv
